/* Bender.yml */
package:
  name: ring_router

sources:
  # design, packages first
  - files:
      - hdl/net_msg_pkg.sv
      - hdl/router_pkg.sv
      - hdl/msg_queue.sv
      - hdl/ring_input_port.sv
      - hdl/term_input_port.sv
      - hdl/output_port_ctrl.sv
      - hdl/ring_router.sv
  # testbench
  - target: any(test, simulation)
    include_dirs:
      - verification
    files:
      - verification/ring_router_tb.sv

/* hdl/msg_queue.sv */
// ----------------------------------------------------------
// small valid/ready queue placed at every router input
// a message enqueued at an edge is visible the cycle after
// ----------------------------------------------------------

`default_nettype none

module msg_queue #(
  parameter int p_num_msgs = 2
) (
  input  logic                  clk,
  input  logic                  arst_n,
  input  logic                  enq_val,
  output logic                  enq_rdy,
  input  net_msg_pkg::net_msg_t enq_msg,
  output logic                  deq_val,
  input  logic                  deq_rdy,
  output net_msg_pkg::net_msg_t deq_msg
);

  import net_msg_pkg::*;

  localparam int c_ptr_nbits = (p_num_msgs > 1) ? $clog2(p_num_msgs) : 1;
  localparam logic [c_ptr_nbits-1:0] c_last = c_ptr_nbits'(p_num_msgs - 1);

  net_msg_t               mem [p_num_msgs];
  logic [c_ptr_nbits-1:0] wr_ptr;
  logic [c_ptr_nbits-1:0] rd_ptr;
  logic                   full;
  logic                   enq_fire;
  logic                   deq_fire;

  assign enq_rdy  = !full;
  assign deq_val  = full || (wr_ptr != rd_ptr);
  assign deq_msg  = mem[rd_ptr];
  assign enq_fire = enq_val && enq_rdy;
  assign deq_fire = deq_val && deq_rdy;

  // storage only, the head is read straight from the array
  always_ff @(posedge clk) begin
    if (enq_fire) begin
      mem[wr_ptr] <= enq_msg;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      full   <= 1'b0;
    end else begin
      if (enq_fire) begin
        wr_ptr <= (wr_ptr == c_last) ? '0 : wr_ptr + 1'b1;
      end
      if (deq_fire) begin
        rd_ptr <= (rd_ptr == c_last) ? '0 : rd_ptr + 1'b1;
      end
      // write catching up with read means every entry is held
      if (enq_fire && !deq_fire) begin
        full <= ((wr_ptr == c_last) ? '0 : wr_ptr + 1'b1) == rd_ptr;
      end else if (deq_fire && !enq_fire) begin
        full <= 1'b0;
      end
    end
  end

  // full only once the write slot has come round to the unread head
  a_full_at_head : assert property (
    @(posedge clk) disable iff (!arst_n) full |-> wr_ptr == rd_ptr);

endmodule

`default_nettype wire

/* hdl/net_msg_pkg.sv */
// ----------------------------------------------------------
// network message format shared by the router and its
// testbench, one packed vector per message
// ----------------------------------------------------------

`default_nettype none

package net_msg_pkg;

  // ----------------------------------------------------------
  // field widths
  // ----------------------------------------------------------

  // router ids, wide enough for an 8 node ring
  localparam int srcdest_nbits = 3;

  // tag carried end to end, never looked at by the router
  localparam int opaque_nbits  = 3;

  localparam int payload_nbits = 32;

  // ----------------------------------------------------------
  // message layout, dest in the top bits
  // ----------------------------------------------------------

  typedef struct packed {
    logic [srcdest_nbits-1:0] dest;
    logic [srcdest_nbits-1:0] src;
    logic [opaque_nbits-1:0]  opaque;
    logic [payload_nbits-1:0] payload;
  } net_msg_t;

endpackage

`default_nettype wire

/* hdl/output_port_ctrl.sv */
// ----------------------------------------------------------
// one router output: round-robin arbiter over the three
// inputs, message selector and domain tag for the link
// ----------------------------------------------------------

`default_nettype none

module output_port_ctrl #(
  parameter int                p_router_id   = 0,
  parameter int                p_num_routers = 8,
  parameter router_pkg::port_e p_port        = router_pkg::port_west
) (
  input  logic                             clk,
  input  logic                             arst_n,
  input  logic [router_pkg::num_ports-1:0] reqs,
  input  net_msg_pkg::net_msg_t            msg_west,
  input  net_msg_pkg::net_msg_t            msg_term,
  input  net_msg_pkg::net_msg_t            msg_east,
  input  router_pkg::domain_e              dom_west,
  input  router_pkg::domain_e              dom_east,
  output logic [router_pkg::num_ports-1:0] grants,
  output logic                             out_val,
  input  logic                             out_rdy,
  output net_msg_pkg::net_msg_t            out_msg,
  output router_pkg::domain_e              out_domain
);

  import router_pkg::*;

  // the wrap-around link of the ring switches traffic into domain 1
  localparam bit c_dateline =
    ((p_port == port_east) && (p_router_id == p_num_routers - 1)) ||
    ((p_port == port_west) && (p_router_id == 0));

  port_e rr_ptr;
  port_e winner;

  // first requester at or after start, scanned backwards so the
  // nearest one is assigned last
  function automatic port_e rr_pick(input logic [num_ports-1:0] req, input port_e start);
    port_e       pick;
    int unsigned idx;
    pick = start;
    for (int i = num_ports - 1; i >= 0; i--) begin
      idx = (int'(start) + i) % num_ports;
      if (req[idx]) begin
        pick = port_e'(idx);
      end
    end
    return pick;
  endfunction

  assign winner  = rr_pick(reqs, rr_ptr);
  assign out_val = |reqs;

  always_comb begin
    grants = '0;
    if (out_val && out_rdy) begin
      grants[winner] = 1'b1;
    end
  end

  always_comb begin
    case (winner)
      port_west: out_msg = msg_west;
      port_east: out_msg = msg_east;
      default:   out_msg = msg_term;
    endcase
  end

  always_comb begin
    if (c_dateline) begin
      out_domain = domain_1;
    end else begin
      case (winner)
        port_west: out_domain = dom_west;
        port_east: out_domain = dom_east;
        default:   out_domain = domain_0;
      endcase
    end
  end

  // priority moves past the winner only when a message leaves
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rr_ptr <= port_west;
    end else if (out_val && out_rdy) begin
      rr_ptr <= (winner == port_east) ? port_west : port_e'(winner + 2'd1);
    end
  end

  // at most one grant, and only to an input that asks for this output
  a_grants_onehot0 : assert property (
    @(posedge clk) disable iff (!arst_n) $onehot0(grants) && ((grants & ~reqs) == '0));

  // a message leaving always dequeues the input it came from
  a_grant_on_transfer : assert property (
    @(posedge clk) disable iff (!arst_n) out_val && out_rdy |-> (grants & reqs) != '0);

endmodule

`default_nettype wire

/* hdl/ring_input_port.sv */
// ----------------------------------------------------------
// one ring side input with a queue per domain; local traffic
// goes to the terminal, the rest continues straight through
// ----------------------------------------------------------

`default_nettype none

module ring_input_port #(
  parameter int                p_router_id   = 0,
  parameter int                p_num_routers = 8,
  parameter int                p_num_msgs    = 2,
  parameter router_pkg::port_e p_port        = router_pkg::port_west
) (
  input  logic                              clk,
  input  logic                              arst_n,
  input  logic                              in_d0_val,
  output logic                              in_d0_rdy,
  input  net_msg_pkg::net_msg_t             in_d0_msg,
  input  logic                              in_d1_val,
  output logic                              in_d1_rdy,
  input  net_msg_pkg::net_msg_t             in_d1_msg,
  output logic [router_pkg::num_ports-1:0]  reqs,
  input  logic                              grant,
  output net_msg_pkg::net_msg_t             head_msg,
  output router_pkg::domain_e               head_domain
);

  import net_msg_pkg::*;
  import router_pkg::*;

  // a message arriving here keeps moving away from where it came in
  localparam port_e c_thru_port = (p_port == port_west) ? port_east : port_west;

  logic     d0_val;
  logic     d1_val;
  net_msg_t d0_msg;
  net_msg_t d1_msg;
  logic     sel_d1;
  logic     head_val;

  msg_queue #(.p_num_msgs(p_num_msgs)) d0_queue (
    .clk     (clk),
    .arst_n  (arst_n),
    .enq_val (in_d0_val),
    .enq_rdy (in_d0_rdy),
    .enq_msg (in_d0_msg),
    .deq_val (d0_val),
    .deq_rdy (grant && !sel_d1),
    .deq_msg (d0_msg)
  );

  msg_queue #(.p_num_msgs(p_num_msgs)) d1_queue (
    .clk     (clk),
    .arst_n  (arst_n),
    .enq_val (in_d1_val),
    .enq_rdy (in_d1_rdy),
    .enq_msg (in_d1_msg),
    .deq_val (d1_val),
    .deq_rdy (grant && sel_d1),
    .deq_msg (d1_msg)
  );

  // domain 1 drains first so the dateline channel never blocks
  assign sel_d1      = d1_val;
  assign head_val    = d0_val || d1_val;
  assign head_msg    = sel_d1 ? d1_msg : d0_msg;
  assign head_domain = sel_d1 ? domain_1 : domain_0;

  always_comb begin
    reqs = '0;
    if (head_msg.dest == srcdest_nbits'(p_router_id)) begin
      reqs[port_term] = head_val;
    end else begin
      reqs[c_thru_port] = head_val;
    end
  end

  // ring traffic never turns back the way it came
  a_no_u_turn : assert property (
    @(posedge clk) disable iff (!arst_n) !reqs[p_port]);

endmodule

`default_nettype wire

/* hdl/ring_router.sv */
// ----------------------------------------------------------
// one node of a bidirectional ring: west, terminal and east
// inputs feeding three arbitrated outputs
// ----------------------------------------------------------

`default_nettype none

module ring_router #(
  parameter int p_router_id   = 0,
  parameter int p_num_routers = 8,
  parameter int p_num_msgs    = 2
) (
  input  logic                  clk,
  input  logic                  arst_n,

  input  logic                  in_west_d0_val,
  output logic                  in_west_d0_rdy,
  input  net_msg_pkg::net_msg_t in_west_d0_msg,
  input  logic                  in_west_d1_val,
  output logic                  in_west_d1_rdy,
  input  net_msg_pkg::net_msg_t in_west_d1_msg,

  input  logic                  in_term_val,
  output logic                  in_term_rdy,
  input  net_msg_pkg::net_msg_t in_term_msg,

  input  logic                  in_east_d0_val,
  output logic                  in_east_d0_rdy,
  input  net_msg_pkg::net_msg_t in_east_d0_msg,
  input  logic                  in_east_d1_val,
  output logic                  in_east_d1_rdy,
  input  net_msg_pkg::net_msg_t in_east_d1_msg,

  output logic                  out_west_val,
  input  logic                  out_west_rdy,
  output net_msg_pkg::net_msg_t out_west_msg,
  output router_pkg::domain_e   out_west_domain,

  output logic                  out_term_val,
  input  logic                  out_term_rdy,
  output net_msg_pkg::net_msg_t out_term_msg,

  output logic                  out_east_val,
  input  logic                  out_east_rdy,
  output net_msg_pkg::net_msg_t out_east_msg,
  output router_pkg::domain_e   out_east_domain
);

  import net_msg_pkg::*;
  import router_pkg::*;

  // ----------------------------------------------------------
  // input side
  // ----------------------------------------------------------

  logic [num_ports-1:0] west_reqs;
  logic [num_ports-1:0] term_reqs;
  logic [num_ports-1:0] east_reqs;
  net_msg_t             west_head;
  net_msg_t             term_head;
  net_msg_t             east_head;
  domain_e              west_dom;
  domain_e              east_dom;

  // grants as seen by each output, bit i for input port i
  logic [num_ports-1:0] out_west_grants;
  logic [num_ports-1:0] out_term_grants;
  logic [num_ports-1:0] out_east_grants;

  ring_input_port #(
    .p_router_id   (p_router_id),
    .p_num_routers (p_num_routers),
    .p_num_msgs    (p_num_msgs),
    .p_port        (port_west)
  ) west_in (
    .clk         (clk),
    .arst_n      (arst_n),
    .in_d0_val   (in_west_d0_val),
    .in_d0_rdy   (in_west_d0_rdy),
    .in_d0_msg   (in_west_d0_msg),
    .in_d1_val   (in_west_d1_val),
    .in_d1_rdy   (in_west_d1_rdy),
    .in_d1_msg   (in_west_d1_msg),
    .reqs        (west_reqs),
    .grant       (out_west_grants[port_west] | out_term_grants[port_west] |
                  out_east_grants[port_west]),
    .head_msg    (west_head),
    .head_domain (west_dom)
  );

  term_input_port #(
    .p_router_id   (p_router_id),
    .p_num_routers (p_num_routers),
    .p_num_msgs    (p_num_msgs)
  ) term_in (
    .clk      (clk),
    .arst_n   (arst_n),
    .in_val   (in_term_val),
    .in_rdy   (in_term_rdy),
    .in_msg   (in_term_msg),
    .reqs     (term_reqs),
    .grant    (out_west_grants[port_term] | out_term_grants[port_term] |
               out_east_grants[port_term]),
    .head_msg (term_head)
  );

  ring_input_port #(
    .p_router_id   (p_router_id),
    .p_num_routers (p_num_routers),
    .p_num_msgs    (p_num_msgs),
    .p_port        (port_east)
  ) east_in (
    .clk         (clk),
    .arst_n      (arst_n),
    .in_d0_val   (in_east_d0_val),
    .in_d0_rdy   (in_east_d0_rdy),
    .in_d0_msg   (in_east_d0_msg),
    .in_d1_val   (in_east_d1_val),
    .in_d1_rdy   (in_east_d1_rdy),
    .in_d1_msg   (in_east_d1_msg),
    .reqs        (east_reqs),
    .grant       (out_west_grants[port_east] | out_term_grants[port_east] |
                  out_east_grants[port_east]),
    .head_msg    (east_head),
    .head_domain (east_dom)
  );

  // ----------------------------------------------------------
  // output side, requests transposed per output
  // ----------------------------------------------------------

  output_port_ctrl #(
    .p_router_id   (p_router_id),
    .p_num_routers (p_num_routers),
    .p_port        (port_west)
  ) west_out (
    .clk        (clk),
    .arst_n     (arst_n),
    .reqs       ({east_reqs[port_west], term_reqs[port_west], west_reqs[port_west]}),
    .msg_west   (west_head),
    .msg_term   (term_head),
    .msg_east   (east_head),
    .dom_west   (west_dom),
    .dom_east   (east_dom),
    .grants     (out_west_grants),
    .out_val    (out_west_val),
    .out_rdy    (out_west_rdy),
    .out_msg    (out_west_msg),
    .out_domain (out_west_domain)
  );

  // the terminal link has no domain
  output_port_ctrl #(
    .p_router_id   (p_router_id),
    .p_num_routers (p_num_routers),
    .p_port        (port_term)
  ) term_out (
    .clk        (clk),
    .arst_n     (arst_n),
    .reqs       ({east_reqs[port_term], term_reqs[port_term], west_reqs[port_term]}),
    .msg_west   (west_head),
    .msg_term   (term_head),
    .msg_east   (east_head),
    .dom_west   (west_dom),
    .dom_east   (east_dom),
    .grants     (out_term_grants),
    .out_val    (out_term_val),
    .out_rdy    (out_term_rdy),
    .out_msg    (out_term_msg),
    .out_domain ()
  );

  output_port_ctrl #(
    .p_router_id   (p_router_id),
    .p_num_routers (p_num_routers),
    .p_port        (port_east)
  ) east_out (
    .clk        (clk),
    .arst_n     (arst_n),
    .reqs       ({east_reqs[port_east], term_reqs[port_east], west_reqs[port_east]}),
    .msg_west   (west_head),
    .msg_term   (term_head),
    .msg_east   (east_head),
    .dom_west   (west_dom),
    .dom_east   (east_dom),
    .grants     (out_east_grants),
    .out_val    (out_east_val),
    .out_rdy    (out_east_rdy),
    .out_msg    (out_east_msg),
    .out_domain (out_east_domain)
  );

endmodule

`default_nettype wire

/* hdl/router_pkg.sv */
// ----------------------------------------------------------
// router port naming and deadlock domains, used for request,
// grant and selector encodings
// ----------------------------------------------------------

`default_nettype none

package router_pkg;

  // ports of one ring node, the index of each bit in reqs and grants
  typedef enum logic [1:0] {
    port_west = 2'd0,
    port_term = 2'd1,
    port_east = 2'd2
  } port_e;

  // domain 1 is entered on the dateline link
  typedef enum logic {
    domain_0 = 1'b0,
    domain_1 = 1'b1
  } domain_e;

  // width of request and grant vectors
  localparam int num_ports = 3;

endpackage

`default_nettype wire

/* hdl/term_input_port.sv */
// ----------------------------------------------------------
// terminal injection queue, picks the shorter ring direction
// and sends east when both ways are equal
// ----------------------------------------------------------

`default_nettype none

module term_input_port #(
  parameter int p_router_id   = 0,
  parameter int p_num_routers = 8,
  parameter int p_num_msgs    = 2
) (
  input  logic                             clk,
  input  logic                             arst_n,
  input  logic                             in_val,
  output logic                             in_rdy,
  input  net_msg_pkg::net_msg_t            in_msg,
  output logic [router_pkg::num_ports-1:0] reqs,
  input  logic                             grant,
  output net_msg_pkg::net_msg_t            head_msg
);

  import router_pkg::*;

  logic        head_val;
  int unsigned east_hops;

  msg_queue #(.p_num_msgs(p_num_msgs)) term_queue (
    .clk     (clk),
    .arst_n  (arst_n),
    .enq_val (in_val),
    .enq_rdy (in_rdy),
    .enq_msg (in_msg),
    .deq_val (head_val),
    .deq_rdy (grant),
    .deq_msg (head_msg)
  );

  // hops needed going east, zero for a local destination
  assign east_hops = (int'(head_msg.dest) + p_num_routers - p_router_id) % p_num_routers;

  always_comb begin
    reqs = '0;
    if (east_hops == 0) begin
      reqs[port_term] = head_val;
    end else if (east_hops <= p_num_routers / 2) begin
      reqs[port_east] = head_val;
    end else begin
      reqs[port_west] = head_val;
    end
  end

endmodule

`default_nettype wire

/* sim.f */
+incdir+verification
hdl/net_msg_pkg.sv
hdl/router_pkg.sv
hdl/msg_queue.sv
hdl/ring_input_port.sv
hdl/term_input_port.sv
hdl/output_port_ctrl.sv
hdl/ring_router.sv
verification/ring_router_tb.sv

/* verification/router_model.svh */
// ----------------------------------------------------------
// reference model for the router testbench: output choice,
// link domain and per-path order of every accepted message
// ----------------------------------------------------------

`ifndef router_model_svh
`define router_model_svh

// input streams, the opaque field of each message carries this id
localparam int stream_west_d0 = 0;
localparam int stream_west_d1 = 1;
localparam int stream_term    = 2;
localparam int stream_east_d0 = 3;
localparam int stream_east_d1 = 4;
localparam int num_streams    = 5;

// one expected FIFO per stream and output, index stream * num_ports + port
net_msg_t exp_fifo [num_streams*num_ports][$];

// output port a message must leave on
function automatic int route_of(input int stream, input logic [srcdest_nbits-1:0] dest);
  int east_hops;
  int port;
  east_hops = (int'(dest) - router_id + num_routers) % num_routers;
  if (east_hops == 0) begin
    port = int'(port_term);
  end else if (stream == stream_west_d0 || stream == stream_west_d1) begin
    port = int'(port_east);
  end else if (stream == stream_east_d0 || stream == stream_east_d1) begin
    port = int'(port_west);
  end else if (east_hops <= num_routers / 2) begin
    // terminal traffic takes the shorter way and goes east on a tie
    port = int'(port_east);
  end else begin
    port = int'(port_west);
  end
  return port;
endfunction

// domain expected on a ring link for a message from the given stream
function automatic domain_e domain_of(input int stream, input int port);
  domain_e dom;
  if (port == port_west && router_id == 0) begin
    dom = domain_1;
  end else if (port == port_east && router_id == num_routers - 1) begin
    dom = domain_1;
  end else if (stream == stream_west_d1 || stream == stream_east_d1) begin
    dom = domain_1;
  end else begin
    dom = domain_0;
  end
  return dom;
endfunction

function automatic void expect_msg(input int stream, input net_msg_t msg);
  exp_fifo[stream * num_ports + route_of(stream, msg.dest)].push_back(msg);
endfunction

function automatic int pending_count();
  int total;
  total = 0;
  for (int i = 0; i < num_streams * num_ports; i++) begin
    total += exp_fifo[i].size();
  end
  return total;
endfunction

`endif

/* verification/ring_router_tb.sv */
// ----------------------------------------------------------
// random traffic testbench for ring router node 0, every
// output transfer is checked against the reference model
// ----------------------------------------------------------

`default_nettype none

module ring_router_tb;

  import net_msg_pkg::*;
  import router_pkg::*;

  localparam int router_id       = 0;
  localparam int num_routers     = 8;
  localparam int msgs_per_stream = 60;
  localparam int cycles_per_msg  = 20;
  localparam int drain_cycles    = 200;

  `include "router_model.svh"

  localparam int timeout_cycles = cycles_per_msg * msgs_per_stream * num_streams;

  logic                   clk;
  logic                   arst_n;
  logic [num_streams-1:0] in_val;
  wire  [num_streams-1:0] in_rdy;
  net_msg_t               in_msg [num_streams];
  wire  [num_ports-1:0]   out_val;
  logic [num_ports-1:0]   out_rdy;
  wire  net_msg_t         out_msg [num_ports];
  domain_e                out_west_domain;
  domain_e                out_east_domain;
  integer                 seed;
  int                     issued [num_streams];
  int                     cycles = 0;

  ring_router #(
    .p_router_id   (router_id),
    .p_num_routers (num_routers)
  ) ring_router_inst (
    .clk             (clk),
    .arst_n          (arst_n),
    .in_west_d0_val  (in_val[stream_west_d0]),
    .in_west_d0_rdy  (in_rdy[stream_west_d0]),
    .in_west_d0_msg  (in_msg[stream_west_d0]),
    .in_west_d1_val  (in_val[stream_west_d1]),
    .in_west_d1_rdy  (in_rdy[stream_west_d1]),
    .in_west_d1_msg  (in_msg[stream_west_d1]),
    .in_term_val     (in_val[stream_term]),
    .in_term_rdy     (in_rdy[stream_term]),
    .in_term_msg     (in_msg[stream_term]),
    .in_east_d0_val  (in_val[stream_east_d0]),
    .in_east_d0_rdy  (in_rdy[stream_east_d0]),
    .in_east_d0_msg  (in_msg[stream_east_d0]),
    .in_east_d1_val  (in_val[stream_east_d1]),
    .in_east_d1_rdy  (in_rdy[stream_east_d1]),
    .in_east_d1_msg  (in_msg[stream_east_d1]),
    .out_west_val    (out_val[port_west]),
    .out_west_rdy    (out_rdy[port_west]),
    .out_west_msg    (out_msg[port_west]),
    .out_west_domain (out_west_domain),
    .out_term_val    (out_val[port_term]),
    .out_term_rdy    (out_rdy[port_term]),
    .out_term_msg    (out_msg[port_term]),
    .out_east_val    (out_val[port_east]),
    .out_east_rdy    (out_rdy[port_east]),
    .out_east_msg    (out_msg[port_east]),
    .out_east_domain (out_east_domain)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #5 clk = ~clk;
    end
  end

  // ----------------------------------------------------------
  // checking helpers
  // ----------------------------------------------------------

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (expected !== actual) begin
      $display("ERROR %s expected %0h actual %0h", name, expected, actual);
      $display("sim failed");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  task automatic fail_run(input string reason);
    $display("%s", reason);
    $display("sim failed");
    $fatal(1, "run aborted");
  endtask

  task automatic check_idle(input string phase);
    check_value({"out val ", phase}, '0, out_val);
    check_value({"in rdy ", phase}, {num_streams{1'b1}}, in_rdy);
  endtask

  // ----------------------------------------------------------
  // stimulus
  // ----------------------------------------------------------

  // ring sides only carry traffic that this node lies on the short path of
  function automatic net_msg_t random_msg(input int stream);
    net_msg_t msg;
    int       pick;
    pick        = $unsigned($random(seed)) % 8;
    msg.payload = $random(seed);
    msg.opaque  = opaque_nbits'(stream);
    msg.src     = srcdest_nbits'($random(seed));
    if (stream == stream_west_d0 || stream == stream_west_d1) begin
      msg.dest = srcdest_nbits'((router_id + pick % 5) % num_routers);
    end else if (stream == stream_term) begin
      msg.src  = srcdest_nbits'(router_id);
      msg.dest = srcdest_nbits'(pick);
    end else if (pick % 4 == 0) begin
      msg.dest = srcdest_nbits'(router_id);
    end else begin
      msg.dest = srcdest_nbits'((router_id + 4 + pick % 4) % num_routers);
    end
    return msg;
  endfunction

  function automatic bit all_issued();
    bit done;
    done = 1'b1;
    for (int i = 0; i < num_streams; i++) begin
      done &= (issued[i] == msgs_per_stream);
    end
    return done;
  endfunction

  // falling edge: new messages where a stream is idle, random back-pressure
  task automatic drive_inputs(input logic [num_streams-1:0] taken);
    for (int i = 0; i < num_streams; i++) begin
      if (!in_val[i] || taken[i]) begin
        in_val[i] = 1'b0;
        if (issued[i] < msgs_per_stream && $random(seed) % 2 == 0) begin
          in_msg[i] = random_msg(i);
          in_val[i] = 1'b1;
          issued[i]++;
        end
      end
    end
    for (int p = 0; p < num_ports; p++) begin
      out_rdy[p] = ($random(seed) % 4) != 0;
    end
  endtask

  task automatic collect_inputs(output logic [num_streams-1:0] taken);
    for (int i = 0; i < num_streams; i++) begin
      taken[i] = in_val[i] && in_rdy[i];
      if (taken[i]) begin
        expect_msg(i, in_msg[i]);
      end
    end
  endtask

  task automatic check_outputs();
    net_msg_t got;
    net_msg_t want;
    int       stream;
    int       idx;
    for (int p = 0; p < num_ports; p++) begin
      if (out_val[p] && out_rdy[p]) begin
        got    = out_msg[p];
        stream = int'(got.opaque);
        idx    = stream * num_ports + p;
        if (stream >= num_streams || exp_fifo[idx].size() == 0) begin
          fail_run($sformatf("output %0d sent a message not expected from stream %0d",
                             p, stream));
        end else begin
          want = exp_fifo[idx].pop_front();
          check_value($sformatf("route and order stream %0d output %0d", stream, p),
                      want, got);
          if (p == port_west) begin
            check_value("west link domain", domain_of(stream, p), out_west_domain);
          end else if (p == port_east) begin
            check_value("east link domain", domain_of(stream, p), out_east_domain);
          end
        end
      end
    end
  endtask

  // ----------------------------------------------------------
  // test sequence
  // ----------------------------------------------------------

  initial begin
    logic [num_streams-1:0] taken;
    int                     wait_cycles;
    seed    = 66;
    arst_n  = 1'b0;
    in_val  = '0;
    out_rdy = '0;
    taken   = '0;
    for (int i = 0; i < num_streams; i++) begin
      in_msg[i] = '0;
      issued[i] = 0;
    end

    repeat (2) begin
      @(negedge clk);
      check_idle("during reset");
    end
    arst_n = 1'b1;
    @(negedge clk);
    check_idle("after reset");

    drive_inputs(taken);
    while (!all_issued() || in_val != '0) begin
      @(posedge clk);
      collect_inputs(taken);
      check_outputs();
      @(negedge clk);
      drive_inputs(taken);
    end

    // nothing new goes in, the router is left to empty
    wait_cycles = 0;
    while (pending_count() != 0 && wait_cycles < drain_cycles) begin
      @(posedge clk);
      check_outputs();
      @(negedge clk);
      drive_inputs('0);
      wait_cycles++;
    end

    if (pending_count() == 0) begin
      $display("sim passed");
      $finish;
    end else begin
      fail_run($sformatf("%0d messages never left the router", pending_count()));
    end
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles > timeout_cycles) begin
      fail_run($sformatf("timeout after %0d cycles with traffic still in flight", cycles));
    end
  end

endmodule

`default_nettype wire
